//--- run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_sensor_channel \
    -f sources.f -o sim_sensor_channel \
    && ./obj_dir/sim_sensor_channel | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sens_cmd_regs.sv
// byte-serial command deserializer with the output mode and line width registers
`timescale 1ns/1ps

module sens_cmd_regs #(
    parameter logic [15:0] SENSOR_BASE_ADDR = 16'h300, // base of this channel
    parameter logic [15:0] SENSOR_ADDR_MASK = 16'h3fe  // bits compared against base
) (
    input  logic                        mclk,
    input  logic                        rst,
    input  logic [7:0]                  cmd_ad_i,     // AL-AH-D0-D1-D2-D3
    input  logic                        cmd_stb_i,    // comes with AL
    output logic                        bit16_o,      // 1: 16-bit output words
    output logic [sens_pkg::HACT_W-1:0] line_width_o  // 0: timer off
);

    localparam int PH_W = $clog2(sens_pkg::CMD_BYTES);
    localparam logic [PH_W-1:0] PH_IDLE  = '0;
    localparam logic [PH_W-1:0] PH_AH    = PH_W'(1);                      // address high next
    localparam logic [PH_W-1:0] PH_D0    = PH_W'(2);                      // first data byte
    localparam logic [PH_W-1:0] PH_LAST  = PH_W'(sens_pkg::CMD_BYTES - 1);

    logic [7:0]                      cmd_ad_r;   // input register
    logic                            cmd_stb_r;
    logic [PH_W-1:0]                 phase;      // byte index of registered byte
    logic [sens_pkg::ADDR_W-1:0]     addr_r;
    logic [sens_pkg::CMD_DATA_W-1:0] data_r;     // D0 ends in low byte
    logic                            addr_hit;
    logic                            wr_en;      // one cycle after last byte
    sens_pkg::ctrl_word_u            cmd_word;
    logic                            bit16_r;
    logic [sens_pkg::HACT_W-1:0]     width_r;

    assign addr_hit = (addr_r & SENSOR_ADDR_MASK) == (SENSOR_BASE_ADDR & SENSOR_ADDR_MASK);
    assign cmd_word = data_r;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmd_stb_r <= 1'b0;
        end else begin
            cmd_stb_r <= cmd_stb_i;
        end
    end

    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad_i;
    end

    // phase sequencer, a strobe always restarts from AL
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            phase <= PH_IDLE;
            wr_en <= 1'b0;
        end else begin
            if (cmd_stb_r) begin
                phase <= PH_AH;                   // AL taken now
            end else if (phase == PH_LAST) begin
                phase <= PH_IDLE;                 // D3 taken now
            end else if (phase != PH_IDLE) begin
                phase <= phase + 1'b1;
            end
            wr_en <= !cmd_stb_r && (phase == PH_LAST) && addr_hit; // aborted by a new strobe
        end
    end

    // address and data assembly
    always_ff @(posedge mclk) begin
        if (cmd_stb_r) begin
            addr_r[sens_pkg::BYTE_W-1:0] <= cmd_ad_r;
        end else if (phase == PH_AH) begin
            addr_r[sens_pkg::ADDR_W-1:sens_pkg::BYTE_W] <= cmd_ad_r;
        end else if (phase >= PH_D0) begin
            data_r <= {cmd_ad_r, data_r[sens_pkg::CMD_DATA_W-1:sens_pkg::BYTE_W]}; // shift in
        end
    end

    // register file, low address bit selects
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            bit16_r <= 1'b0;                      // 8-bit mode
            width_r <= '0;                        // timer off
        end else if (wr_en) begin
            if (addr_r[0] == sens_pkg::REG_CTRL) begin
                bit16_r <= cmd_word.mode.bit16;
            end else if (addr_r[0] == sens_pkg::REG_WIDTH) begin
                width_r <= cmd_word.line.width;
            end
        end
    end

    assign bit16_o      = bit16_r;
    assign line_width_o = width_r;

endmodule

//--- sens_hact_timer.sv
// line-active regenerator, fixed duration from the line start or pass-through when width is 0
`timescale 1ns/1ps

module sens_hact_timer (
    input  logic                        mclk,
    input  logic                        rst,
    input  logic                        hact_i,   // line active from sensor
    input  logic [sens_pkg::HACT_W-1:0] width_i,  // line length in pixels, 0 = off
    output logic                        hact_o    // registered line active
);

    logic                        hact_d;   // previous input, edge detect
    logic [sens_pkg::HACT_W-1:0] cnt;      // cycles left after current one
    logic                        hact_r;
    logic                        start;

    assign start = hact_i && !hact_d && (cnt == '0); // busy timer ignores edges

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            hact_d <= 1'b0;
            cnt    <= '0;
            hact_r <= 1'b0;
        end else begin
            hact_d <= hact_i;
            if (width_i == '0) begin
                cnt    <= '0;
                hact_r <= hact_i;             // plain delay
            end else if (start) begin
                cnt    <= width_i - 1'b1;     // first cycle counts
                hact_r <= 1'b1;
            end else if (cnt != '0) begin
                cnt    <= cnt - 1'b1;
                hact_r <= 1'b1;
            end else begin
                hact_r <= 1'b0;               // line done
            end
        end
    end

    assign hact_o = hact_r;

endmodule

//--- sens_pix_if.sv
// registered pixel stream from the input sync stage to the output packer, all in mclk
`timescale 1ns/1ps

interface sens_pix_if;

    logic [sens_pkg::PXD_W-1:0] pxd;  // pixel data, valid while hact
    logic                       hact; // line active, possibly regenerated
    logic                       sof;  // start of frame pulse
    logic                       eof;  // end of frame pulse

    // sync stage side
    modport src (
        output pxd,
        output hact,
        output sof,
        output eof
    );

    // packer side
    modport dst (
        input  pxd,
        input  hact,
        input  sof,
        input  eof
    );

endinterface

//--- sens_pixel_pack.sv
// output packer, 12-bit pixels as MSB-aligned words or two 8-bit pixels per word
`timescale 1ns/1ps

module sens_pixel_pack (
    input  logic                        mclk,
    input  logic                        rst,
    sens_pix_if.dst                     pix,
    input  logic                        bit16_i,       // 1: one pixel per word
    output logic [sens_pkg::DOUT_W-1:0] dout_o,
    output logic                        dout_valid_o,
    output logic                        sof_o,
    output logic                        eof_o
);

    localparam int PAD_W = sens_pkg::DOUT_W - sens_pkg::PXD_W;

    logic [sens_pkg::BYTE_W-1:0] pix_byte;   // upper pixel bits
    logic [sens_pkg::BYTE_W-1:0] first_r;    // held first byte of a pair
    logic                        odd_r;      // first byte stored
    logic [sens_pkg::DOUT_W-1:0] dout_r;
    logic                        dav_r;
    logic                        sof_r;
    logic                        eof_r;

    assign pix_byte = pix.pxd[sens_pkg::PXD_W-1 -: sens_pkg::BYTE_W];

    // control side
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            odd_r <= 1'b0;
            dav_r <= 1'b0;
            sof_r <= 1'b0;
            eof_r <= 1'b0;
        end else begin
            odd_r <= !bit16_i && pix.hact && !odd_r;   // cleared outside lines
            dav_r <= pix.hact && (bit16_i || odd_r);  // second byte completes a word
            sof_r <= pix.sof;                         // same latency as data
            eof_r <= pix.eof;
        end
    end

    // data side, held between words
    always_ff @(posedge mclk) begin
        if (pix.hact && !odd_r) begin
            first_r <= pix_byte;
        end
        if (pix.hact && bit16_i) begin
            dout_r <= {pix.pxd, {PAD_W{1'b0}}};
        end else if (pix.hact && odd_r) begin
            dout_r <= {first_r, pix_byte};            // earlier pixel high
        end
    end

    assign dout_o       = dout_r;
    assign dout_valid_o = dav_r;
    assign sof_o        = sof_r;
    assign eof_o        = eof_r;

endmodule

//--- sens_pkg.sv
// shared widths, register indices and the command data word of the sensor channel
package sens_pkg;

    parameter int PXD_W      = 12;  // sensor pixel bits
    parameter int DOUT_W     = 16;  // output word bits
    parameter int BYTE_W     = 8;   // command byte, also 8-bit mode pixel
    parameter int CMD_BYTES  = 6;   // AL, AH, D0..D3
    parameter int HACT_W     = 16;  // line width register
    parameter int ADDR_W     = 16;  // two address bytes
    parameter int CMD_DATA_W = 32;  // four data bytes

    // register select, low address bit
    parameter bit REG_CTRL   = 1'b0;
    parameter bit REG_WIDTH  = 1'b1;

    parameter int CTRL_BIT16 = 8;   // mode bit position in control word

    // command data word, seen as mode word or as line width word
    typedef union packed {
        struct packed {
            logic [CMD_DATA_W-CTRL_BIT16-2:0] rsvd_hi; // former histogram bits live above
            logic                             bit16;   // 1: 16-bit words, 0: packed bytes
            logic [CTRL_BIT16-1:0]            rsvd_lo; // histogram enables, unused here
        } mode;
        struct packed {
            logic [CMD_DATA_W-HACT_W-1:0] rsvd;  // ignored
            logic [HACT_W-1:0]            width; // 0: follow input line-active
        } line;
    } ctrl_word_u;

endpackage

//--- sens_sync_in.sv
// input register stage for the parallel sensor bus, builds frame pulses and the pixel stream
`timescale 1ns/1ps

module sens_sync_in (
    input  logic                        mclk,
    input  logic                        rst,
    input  logic [sens_pkg::PXD_W-1:0]  pxd_i,         // pixel data
    input  logic                        hact_i,        // line active
    input  logic                        vact_i,        // frame active
    input  logic [sens_pkg::HACT_W-1:0] line_width_i,  // to the timer
    sens_pix_if.src                     pix
);

    logic [sens_pkg::PXD_W-1:0] pxd_r;
    logic                       vact_r;
    logic                       sof_r;
    logic                       eof_r;
    logic                       hact_gen;  // same stage as pxd_r

    always_ff @(posedge mclk) begin
        pxd_r <= pxd_i;
    end

    // frame edges
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            vact_r <= 1'b0;
            sof_r  <= 1'b0;
            eof_r  <= 1'b0;
        end else begin
            vact_r <= vact_i;
            sof_r  <= vact_i && !vact_r;   // rising
            eof_r  <= !vact_i && vact_r;   // falling
        end
    end

    sens_hact_timer u_hact_timer (
        .mclk    (mclk),
        .rst     (rst),
        .hact_i  (hact_i),
        .width_i (line_width_i),
        .hact_o  (hact_gen)
    );

    assign pix.pxd  = pxd_r;
    assign pix.hact = hact_gen;
    assign pix.sof  = sof_r;
    assign pix.eof  = eof_r;

endmodule

//--- sensor_channel.sv
// sensor channel top, command registers, input sync and output packer in the mclk domain
`timescale 1ns/1ps

module sensor_channel #(
    parameter logic [15:0] SENSOR_BASE_ADDR = 16'h300, // channel register base
    parameter logic [15:0] SENSOR_ADDR_MASK = 16'h3fe  // two registers
) (
    input  logic                        mclk,
    input  logic                        rst,
    input  logic [7:0]                  cmd_ad_i,      // command bytes
    input  logic                        cmd_stb_i,     // with first byte
    input  logic [sens_pkg::PXD_W-1:0]  pxd_i,         // sensor pixel
    input  logic                        hact_i,        // sensor line active
    input  logic                        vact_i,        // sensor frame active
    output logic [sens_pkg::DOUT_W-1:0] dout_o,
    output logic                        dout_valid_o,
    output logic                        sof_o,
    output logic                        eof_o
);

    logic                        bit16;       // output mode
    logic [sens_pkg::HACT_W-1:0] line_width;  // programmed line length

    sens_pix_if pix_bus ();

    sens_cmd_regs #(
        .SENSOR_BASE_ADDR (SENSOR_BASE_ADDR),
        .SENSOR_ADDR_MASK (SENSOR_ADDR_MASK)
    ) u_cmd_regs (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_ad_i     (cmd_ad_i),
        .cmd_stb_i    (cmd_stb_i),
        .bit16_o      (bit16),
        .line_width_o (line_width)
    );

    sens_sync_in u_sync_in (
        .mclk         (mclk),
        .rst          (rst),
        .pxd_i        (pxd_i),
        .hact_i       (hact_i),
        .vact_i       (vact_i),
        .line_width_i (line_width),
        .pix          (pix_bus.src)
    );

    sens_pixel_pack u_pixel_pack (
        .mclk         (mclk),
        .rst          (rst),
        .pix          (pix_bus.dst),
        .bit16_i      (bit16),
        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .sof_o        (sof_o),
        .eof_o        (eof_o)
    );

endmodule

//--- sensor_channel_sva.sv
// assertions bound into the sensor channel top, reset values, frame pulses and byte mode spacing
`timescale 1ns/1ps

module sensor_channel_sva (
    input  logic mclk,
    input  logic rst,
    input  logic bit16_i,       // mode register
    input  logic dout_valid_i,
    input  logic sof_i,
    input  logic eof_i
);

    quiet_in_reset: assert property (@(posedge mclk) rst |-> !dout_valid_i && !sof_i && !eof_i)
        else $error("output strobe active while reset is high");

    pulses_apart: assert property (@(posedge mclk) disable iff (rst) !(sof_i && eof_i))
        else $error("start and end of frame in the same cycle");

    // one word per pixel pair
    byte_mode_gap: assert property (@(posedge mclk) disable iff (rst)
        (dout_valid_i && !bit16_i) |=> !dout_valid_i)
        else $error("back to back words in 8-bit mode");

endmodule

bind sensor_channel sensor_channel_sva u_sva (
    .mclk         (mclk),
    .rst          (rst),
    .bit16_i      (bit16),
    .dout_valid_i (dout_valid_o),
    .sof_i        (sof_o),
    .eof_i        (eof_o)
);

//--- sources.f
sens_pkg.sv
sens_pix_if.sv
sens_cmd_regs.sv
sens_hact_timer.sv
sens_sync_in.sv
sens_pixel_pack.sv
sensor_channel.sv
sensor_channel_sva.sv
tb_sensor_checker.sv
tb_sensor_channel.sv

//--- tb_sensor_channel.sv
// testbench top for the sensor channel, drives commands and frames and sequences the tests
`timescale 1ns/1ps

module tb_sensor_channel;

    localparam logic [15:0] BASE = 16'h300;
    localparam logic [15:0] MASK = 16'h3fe;

    logic                        mclk;
    logic                        rst;
    logic [7:0]                  cmd_ad_i;
    logic                        cmd_stb_i;
    logic [sens_pkg::PXD_W-1:0]  pxd_i;
    logic                        hact_i;
    logic                        vact_i;
    logic [sens_pkg::DOUT_W-1:0] dout_o;
    logic                        dout_valid_o;
    logic                        sof_o;
    logic                        eof_o;
    logic                        mode16_m;  // model of the mode register
    logic [15:0]                 width_m;   // model of the width register
    int                          seed = 64583;
    int                          err_mark;  // errors before the running test

    sensor_channel #(.SENSOR_BASE_ADDR(BASE), .SENSOR_ADDR_MASK(MASK)) DUT (
        .mclk(mclk), .rst(rst), .cmd_ad_i(cmd_ad_i), .cmd_stb_i(cmd_stb_i),
        .pxd_i(pxd_i), .hact_i(hact_i), .vact_i(vact_i), .dout_o(dout_o),
        .dout_valid_o(dout_valid_o), .sof_o(sof_o), .eof_o(eof_o)
    );

    tb_sensor_checker u_checker (
        .mclk(mclk), .rst(rst), .dout_i(dout_o), .dout_valid_i(dout_valid_o),
        .sof_i(sof_o), .eof_i(eof_o)
    );

    always #5 mclk = ~mclk;

    // word from one pixel, or from a pair in byte mode
    function automatic logic [15:0] ref_word(input logic m16, input logic [11:0] p0,
                                             input logic [11:0] p1);
        if (m16) begin
            ref_word = {p0, 4'h0};
        end else begin
            ref_word = {p0[11:4], p1[11:4]};
        end
    endfunction

    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [7:0] seq [6];
        seq = '{addr[7:0], addr[15:8], data[7:0], data[15:8], data[23:16], data[31:24]};
        for (int i = 0; i < 6; i++) begin
            @(posedge mclk);
            #1;
            cmd_ad_i  = seq[i];
            cmd_stb_i = (i == 0);  // strobe with AL only
        end
        @(posedge mclk);
        #1;
        cmd_ad_i = 8'h00;
        if ((addr & MASK) == (BASE & MASK)) begin  // other bases are ignored
            if (addr[0]) width_m = data[15:0];
            else mode16_m = data[8];
        end
        repeat (10) @(posedge mclk);
    endtask

    task automatic drive_line(input int len);
        int          n_out;  // pixels that become words
        int          span;   // cycles pixels are driven
        logic [11:0] p;
        logic [11:0] first;
        n_out = (width_m == 16'h0) ? len : int'(width_m);
        span  = (len > n_out) ? len : n_out;  // timer may outlast hact_i
        first = 12'h0;
        for (int i = 0; i < span; i++) begin
            @(posedge mclk);
            #1;
            p      = 12'($random(seed));
            pxd_i  = p;
            hact_i = (i < len);
            if (i < n_out && mode16_m) begin
                u_checker.word_q.push_back(ref_word(1'b1, p, 12'h0));
                u_checker.due_q.push_back(u_checker.cyc + 2);
            end else if (i < n_out && i % 2 == 0) begin
                first = p;
            end else if (i < n_out) begin
                u_checker.word_q.push_back(ref_word(1'b0, first, p));
                u_checker.due_q.push_back(u_checker.cyc + 2);
            end
        end
        @(posedge mclk);
        #1;
        hact_i = 1'b0;
        repeat (4) @(posedge mclk);  // line gap
    endtask

    task automatic set_frame(input logic level);
        @(posedge mclk);
        #1;
        vact_i = level;
        if (level) u_checker.sof_q.push_back(u_checker.cyc + 2);
        else u_checker.eof_q.push_back(u_checker.cyc + 2);
        repeat (2) @(posedge mclk);
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        while (u_checker.word_q.size() + u_checker.sof_q.size() + u_checker.eof_q.size() != 0
               && n < 100) begin
            @(posedge mclk);
            n++;
        end
        if (u_checker.word_q.size() + u_checker.sof_q.size() + u_checker.eof_q.size() != 0) begin
            $display("timeout in %s, expected words or frame pulses never came out", name);
            $display("*** TEST FAILED ***");
            $finish;
        end
        repeat (4) @(posedge mclk);  // catch stray words
        $display("test %-16s done, %0d errors", name, u_checker.err_cnt - err_mark);
        err_mark = u_checker.err_cnt;
    endtask

    initial begin
        mclk = 1'b0;
        rst = 1'b1;
        cmd_ad_i = 8'h00;
        cmd_stb_i = 1'b0;
        pxd_i = '0;
        hact_i = 1'b0;
        vact_i = 1'b0;
        mode16_m = 1'b0;  // reset values
        width_m = 16'h0;
        err_mark = 0;
        repeat (8) @(posedge mclk);
        #1 rst = 1'b0;
        repeat (20) @(posedge mclk);  // checker flags anything seen here
        set_frame(1'b1);
        drive_line(8);
        set_frame(1'b0);
        finish_test("reset state");
        send_cmd(BASE, 32'h0000_0100);  // bit16 on
        set_frame(1'b1);
        drive_line(6);
        drive_line(9);
        set_frame(1'b0);
        finish_test("16-bit mode");
        send_cmd(BASE, 32'h0000_0000);
        set_frame(1'b1);
        drive_line(8);
        drive_line(12);
        set_frame(1'b0);
        finish_test("8-bit mode");
        send_cmd(BASE, 32'h0000_0100);
        send_cmd(BASE | 16'h1, 32'h0000_0006);  // 6 pixels per line
        set_frame(1'b1);
        drive_line(10);
        drive_line(3);
        set_frame(1'b0);
        send_cmd(BASE | 16'h1, 32'h0000_0000);
        set_frame(1'b1);
        drive_line(9);
        set_frame(1'b0);
        finish_test("line timer");
        send_cmd(16'h310, 32'h0000_0000);  // outside the mask
        send_cmd(16'h313, 32'h0000_0005);
        set_frame(1'b1);
        drive_line(7);
        set_frame(1'b0);
        finish_test("address match");
        set_frame(1'b1);
        drive_line(4);
        set_frame(1'b0);
        set_frame(1'b1);  // frame without lines
        set_frame(1'b0);
        send_cmd(BASE, 32'h0000_0000);
        set_frame(1'b1);
        drive_line(6);
        set_frame(1'b0);
        finish_test("frame pulses");
        $display("words %0d, sof %0d, eof %0d, errors %0d", u_checker.word_cnt,
                 u_checker.sof_cnt, u_checker.eof_cnt, u_checker.err_cnt);
        if (u_checker.err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb_sensor_checker.sv
// testbench checker, compares every output word and frame pulse of the sensor channel in order
`timescale 1ns/1ps

module tb_sensor_checker (
    input  logic                        mclk,
    input  logic                        rst,
    input  logic [sens_pkg::DOUT_W-1:0] dout_i,
    input  logic                        dout_valid_i,
    input  logic                        sof_i,
    input  logic                        eof_i
);

    logic [sens_pkg::DOUT_W-1:0] word_q [$];  // expected words, filled by the stimulus
    int                          due_q  [$];  // cycle each word must show up
    int                          sof_q  [$];  // expected sof cycles
    int                          eof_q  [$];  // expected eof cycles
    int                          cyc      = 0;  // rising edges so far
    int                          err_cnt  = 0;
    int                          word_cnt = 0;
    int                          sof_cnt  = 0;
    int                          eof_cnt  = 0;

    always @(posedge mclk) begin
        cyc <= cyc + 1;
    end

    // outputs settle half a cycle after the edge
    always @(negedge mclk) begin : compare
        logic [sens_pkg::DOUT_W-1:0] w;
        int                          due;
        if (!rst) begin
            if (dout_valid_i) begin
                word_cnt++;
                if (word_q.size() == 0) begin
                    err_cnt++;
                    $display("unexpected output word 0x%04h at cycle %0d", dout_i, cyc);
                end else begin
                    w   = word_q.pop_front();
                    due = due_q.pop_front();
                    if (dout_i !== w) begin
                        err_cnt++;
                        $display("ERR dout_o exp 0x%04h got 0x%04h", w, dout_i);
                    end
                    if (cyc != due) begin
                        err_cnt++;
                        $display("word 0x%04h came at cycle %0d instead of %0d", w, cyc, due);
                    end
                end
            end
            if (sof_i) begin
                sof_cnt++;
                if (sof_q.size() == 0 || sof_q[0] != cyc) begin
                    err_cnt++;
                    $display("start of frame pulse at cycle %0d was not expected", cyc);
                end
                if (sof_q.size() != 0) begin
                    void'(sof_q.pop_front());
                end
            end
            if (eof_i) begin
                eof_cnt++;
                if (eof_q.size() == 0 || eof_q[0] != cyc) begin
                    err_cnt++;
                    $display("end of frame pulse at cycle %0d was not expected", cyc);
                end
                if (eof_q.size() != 0) begin
                    void'(eof_q.pop_front());
                end
            end
        end
    end

endmodule
